// File: common/pipe_defs.svh
/*
 * Width and offset macros for the MEM2/WB pipeline tail.
 * Included by the package and by any module that needs a raw width
 * or the link offset. The guard allows repeated inclusion.
 */

`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// data path and PC width
`define WORD_W 32

// GPR index width for 32 registers
`define REG_IDX_W 5

// JAL/JALR link value is PC plus this, skipping the delay slot
`define LINK_OFFSET 8

`endif

// File: common/pipePkg.sv
/*
 * Shared types for the pipeline tail: data words, register numbers,
 * write-flag vectors and the write-back and load selectors.
 * Referenced by scoped names from every stage.
 */

`include "pipe_defs.svh"

package pipePkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    // bit 0 GPR, bit 1 HI, bit 2 LO
    typedef logic [2:0] regsWr_t;

    // write-back source select
    typedef enum logic [1:0] {
        wbLink     = 2'b00, // PC plus link offset
        wbAlu      = 2'b01,
        wbOperandB = 2'b10, // MTHI/MTLO and friends
        wbLoad     = 2'b11
    } wbSel_t;

    typedef enum logic [2:0] {
        ldNone  = 3'd0,
        ldByte  = 3'd1, // LB
        ldByteU = 3'd2, // LBU
        ldHalf  = 3'd3, // LH
        ldHalfU = 3'd4, // LHU
        ldWord  = 3'd5  // LW
    } loadType_t;

endpackage

// File: common/mem2WbIf.sv
/*
 * Registered MEM2 instruction fields. The MEM2 register drives them
 * through the stage modport; the bypass mux, the load aligner and the
 * write-back register each read their subset.
 */

`timescale 1ns/1ps

interface mem2WbIf;

    pipePkg::word_t     pc;
    pipePkg::word_t     aluOut;   // also the load address
    pipePkg::word_t     outB;
    pipePkg::wbSel_t    wbSel;
    pipePkg::regIdx_t   dst;
    pipePkg::regsWr_t   regsWr;
    pipePkg::loadType_t loadType;

    modport stage (
        output pc, aluOut, outB, wbSel, dst, regsWr, loadType
    );

    modport bypass (
        input pc, aluOut, outB, wbSel, dst, regsWr
    );

    // only the address low bits and the load kind
    modport load (
        input aluOut, loadType
    );

    modport wb (
        input wbSel, dst, regsWr
    );

endinterface

// File: mem2/mem2Reg.sv
/*
 * MEM to MEM2 pipeline register. Captures the instruction on advance,
 * holds it otherwise. Reset and flush load a bubble, and flush wins
 * over advance.
 */

`timescale 1ns/1ps

module mem2Reg (
    input  logic               clk,
    input  logic               rstN,
    input  logic               flush,
    input  logic               advance,
    input  pipePkg::word_t     memPc,
    input  pipePkg::word_t     memAluOut,
    input  pipePkg::word_t     memOutB,
    input  pipePkg::wbSel_t    memWbSel,
    input  pipePkg::regIdx_t   memDst,
    input  pipePkg::regsWr_t   memRegsWr,
    input  pipePkg::loadType_t memLoadType,
    mem2WbIf.stage             m2
);

    logic loadBubble;

    assign loadBubble = !rstN || flush;

    always_ff @(posedge clk) begin
        if (loadBubble) begin
            // bubble has no writes, no load and a harmless ALU select
            m2.pc       <= '0;
            m2.aluOut   <= '0;
            m2.outB     <= '0;
            m2.wbSel    <= pipePkg::wbAlu;
            m2.dst      <= '0;
            m2.regsWr   <= '0;
            m2.loadType <= pipePkg::ldNone;
        end else if (advance) begin
            m2.pc       <= memPc;
            m2.aluOut   <= memAluOut;
            m2.outB     <= memOutB;
            m2.wbSel    <= memWbSel;
            m2.dst      <= memDst;
            m2.regsWr   <= memRegsWr;
            m2.loadType <= memLoadType;
        end
        // everything holds on a stall
    end

endmodule

// File: mem2/bypassSelect.sv
/*
 * MEM2 forwarding result. Picks link address, ALU result or operand B
 * by the write-back select and masks the GPR write flag for r0.
 * Purely combinational, sits beside the load aligner.
 */

`timescale 1ns/1ps

`include "pipe_defs.svh"

module bypassSelect (
    mem2WbIf.bypass            m2,
    output pipePkg::word_t     bypassResult,
    output pipePkg::regIdx_t   fwdDst,
    output pipePkg::regsWr_t   fwdRegsWr
);

    pipePkg::word_t linkAddr;
    logic           dstIsZero;

    assign linkAddr  = m2.pc + `WORD_W'(`LINK_OFFSET); // JAL/JALR return address
    assign dstIsZero = (m2.dst == '0);

    always_comb begin
        case (m2.wbSel)
            pipePkg::wbLink:     bypassResult = linkAddr;
            pipePkg::wbAlu:      bypassResult = m2.aluOut;
            pipePkg::wbOperandB: bypassResult = m2.outB;
            // hazard unit stalls on loadType while load data is not ready
            pipePkg::wbLoad:     bypassResult = m2.aluOut;
            default:             bypassResult = m2.aluOut;
        endcase
    end

    assign fwdDst = m2.dst;

    // r0 writes are dropped here, so they never forward or commit
    assign fwdRegsWr = {m2.regsWr[2:1], m2.regsWr[0] & ~dstIsZero};

endmodule

// File: mem2/loadAlign.sv
/*
 * Load data alignment for the little-endian data bus. Uses the low two
 * address bits to pick the byte or halfword from the returned word,
 * then sign- or zero-extends by load type. Combinational.
 */

`timescale 1ns/1ps

module loadAlign (
    mem2WbIf.load          m2,
    input  pipePkg::word_t dbusRdata,
    output pipePkg::word_t loadData
);

    logic [1:0]  byteOffset;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    assign byteOffset = m2.aluOut[1:0];

    always_comb begin
        case (byteOffset)
            2'd0:    loadByte = dbusRdata[7:0];
            2'd1:    loadByte = dbusRdata[15:8];
            2'd2:    loadByte = dbusRdata[23:16];
            default: loadByte = dbusRdata[31:24];
        endcase
    end

    // halfword position from bit 1 only
    assign loadHalf = byteOffset[1] ? dbusRdata[31:16] : dbusRdata[15:0];

    always_comb begin
        case (m2.loadType)
            pipePkg::ldByte: begin
                loadData = {{24{loadByte[7]}}, loadByte};
            end
            pipePkg::ldByteU: begin
                loadData = {24'd0, loadByte};
            end
            pipePkg::ldHalf: begin
                loadData = {{16{loadHalf[15]}}, loadHalf};
            end
            pipePkg::ldHalfU: begin
                loadData = {16'd0, loadHalf};
            end
            pipePkg::ldWord: begin
                loadData = dbusRdata;
            end
            default: begin
                loadData = '0; // ldNone
            end
        endcase
    end

endmodule

// File: hdl/wbStage.sv
/*
 * MEM2 to WB register and write-back mux. Registers the write flags and
 * both candidate words on advance, inserts a bubble when MEM2 stalls,
 * and drives the register file and HI/LO write ports.
 */

`timescale 1ns/1ps

module wbStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             advance,
    mem2WbIf.wb              m2,
    input  pipePkg::word_t   bypassResult,
    input  pipePkg::word_t   loadData,
    input  pipePkg::regsWr_t fwdRegsWr,
    output logic             rfWe,
    output pipePkg::regIdx_t rfAddr,
    output pipePkg::word_t   rfData,
    output logic             hiWe,
    output logic             loWe,
    output pipePkg::word_t   hiLoData
);

    pipePkg::regsWr_t regsWrQ;
    pipePkg::regIdx_t dstQ;
    pipePkg::wbSel_t  wbSelQ;
    pipePkg::word_t   bypassQ;
    pipePkg::word_t   loadQ;
    logic             capturePayload;

    // a stall turns the write flags into a bubble
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regsWrQ <= '0;
        end else if (advance) begin
            regsWrQ <= fwdRegsWr;
        end else begin
            regsWrQ <= '0;
        end
    end

    // data only moves when something will be written
    assign capturePayload = advance && (m2.regsWr != '0);

    always_ff @(posedge clk) begin
        if (capturePayload) begin
            dstQ    <= m2.dst;
            wbSelQ  <= m2.wbSel;
            bypassQ <= bypassResult;
            loadQ   <= loadData;
        end
    end

    assign rfWe     = regsWrQ[0];
    assign hiWe     = regsWrQ[1];
    assign loWe     = regsWrQ[2];
    assign rfAddr   = dstQ;
    assign rfData   = (wbSelQ == pipePkg::wbLoad) ? loadQ : bypassQ;
    assign hiLoData = bypassQ; // outB for MTHI/MTLO

endmodule

// File: hdl/memTail.sv
/*
 * Top of the pipeline tail: MEM2 register, bypass mux, load aligner and
 * write-back stage. Takes the MEM fields and the data-bus read word,
 * gives the MEM2 forwarding values and the write ports.
 */

`timescale 1ns/1ps

module memTail (
    input  logic               clk,
    input  logic               rstN,
    input  logic               flush,
    input  logic               advance,
    input  pipePkg::word_t     memPc,
    input  pipePkg::word_t     memAluOut,
    input  pipePkg::word_t     memOutB,
    input  pipePkg::wbSel_t    memWbSel,
    input  pipePkg::regIdx_t   memDst,
    input  pipePkg::regsWr_t   memRegsWr,
    input  pipePkg::loadType_t memLoadType,
    input  pipePkg::word_t     dbusRdata,   // valid during MEM2
    output pipePkg::word_t     mem2Result,
    output pipePkg::regIdx_t   mem2Dst,
    output pipePkg::regsWr_t   mem2RegsWr,
    output pipePkg::loadType_t mem2LoadType,
    output logic               rfWe,
    output pipePkg::regIdx_t   rfAddr,
    output pipePkg::word_t     rfData,
    output logic               hiWe,
    output logic               loWe,
    output pipePkg::word_t     hiLoData
);

    mem2WbIf m2 ();

    pipePkg::word_t loadData;

    mem2Reg i_mem2Reg (
        .clk         (clk),
        .rstN        (rstN),
        .flush       (flush),
        .advance     (advance),
        .memPc       (memPc),
        .memAluOut   (memAluOut),
        .memOutB     (memOutB),
        .memWbSel    (memWbSel),
        .memDst      (memDst),
        .memRegsWr   (memRegsWr),
        .memLoadType (memLoadType),
        .m2          (m2.stage)
    );

    bypassSelect i_bypassSelect (
        .m2           (m2.bypass),
        .bypassResult (mem2Result),
        .fwdDst       (mem2Dst),
        .fwdRegsWr    (mem2RegsWr)
    );

    loadAlign i_loadAlign (
        .m2        (m2.load),
        .dbusRdata (dbusRdata),
        .loadData  (loadData)
    );

    // hazard unit needs the load kind to stall dependants
    assign mem2LoadType = m2.loadType;

    wbStage i_wbStage (
        .clk          (clk),
        .rstN         (rstN),
        .advance      (advance),
        .m2           (m2.wb),
        .bypassResult (mem2Result),
        .loadData     (loadData),
        .fwdRegsWr    (mem2RegsWr),
        .rfWe         (rfWe),
        .rfAddr       (rfAddr),
        .rfData       (rfData),
        .hiWe         (hiWe),
        .loWe         (loWe),
        .hiLoData     (hiLoData)
    );

endmodule

// File: verif/tbChecks.svh
/*
 * Drive tasks, reference model and typed compare tasks for tbMemTail.
 * Included inside the testbench module, after its signal declarations.
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic pipePkg::word_t randomWord();
    return $urandom();
endfunction

function automatic pipePkg::regIdx_t randomDst();
    return pipePkg::regIdx_t'($urandom_range(31, 1)); // never r0
endfunction

// forwarding value by write-back select
function automatic pipePkg::word_t modelBypass(input pipePkg::wbSel_t sel,
        input pipePkg::word_t pc, input pipePkg::word_t aluOut, input pipePkg::word_t outB);
    case (sel)
        pipePkg::wbLink:     return pc + 32'd8;
        pipePkg::wbOperandB: return outB;
        default:             return aluOut; // load select forwards the address
    endcase
endfunction

// little-endian lane pick followed by extension
function automatic pipePkg::word_t modelLoad(input pipePkg::loadType_t lt,
        input pipePkg::word_t addr, input pipePkg::word_t rdata);
    pipePkg::word_t byteLane;
    pipePkg::word_t halfLane;
    pipePkg::word_t result;
    byteLane = rdata >> {addr[1:0], 3'b000};
    halfLane = rdata >> {addr[1], 4'b0000};
    case (lt)
        pipePkg::ldByte, pipePkg::ldByteU: begin
            result = byteLane & 32'h0000_00ff;
        end
        pipePkg::ldHalf, pipePkg::ldHalfU: begin
            result = halfLane & 32'h0000_ffff;
        end
        pipePkg::ldWord: begin
            result = rdata;
        end
        default: begin
            result = '0;
        end
    endcase
    if (lt == pipePkg::ldByte && byteLane[7]) begin
        result = result | 32'hffff_ff00;
    end
    if (lt == pipePkg::ldHalf && halfLane[15]) begin
        result = result | 32'hffff_0000;
    end
    return result;
endfunction

// only the GPR write is dropped for r0
function automatic pipePkg::regsWr_t modelFlags(input pipePkg::regsWr_t wr,
        input pipePkg::regIdx_t dst);
    pipePkg::regsWr_t flags;
    flags = wr;
    if (dst == 5'd0) begin
        flags[0] = 1'b0;
    end
    return flags;
endfunction

task automatic checkWord(input string name, input pipePkg::word_t got,
        input pipePkg::word_t expected);
    checkCount++;
    if (got !== expected) begin
        errorCount++;
        $display("Error: %s got 0x%08h expected 0x%08h", name, got, expected);
    end
endtask

task automatic checkFlags(input string name, input pipePkg::regsWr_t got,
        input pipePkg::regsWr_t expected);
    checkCount++;
    if (got !== expected) begin
        errorCount++;
        $display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
    end
endtask

task automatic noteFailure(input string msg);
    errorCount++;
    $display("%s", msg);
endtask

task automatic driveInstr(input pipePkg::wbSel_t sel, input pipePkg::word_t pc,
        input pipePkg::word_t aluOut, input pipePkg::word_t outB,
        input pipePkg::regIdx_t dst, input pipePkg::regsWr_t wr, input pipePkg::loadType_t lt);
    memWbSel    <= sel;
    memPc       <= pc;
    memAluOut   <= aluOut;
    memOutB     <= outB;
    memDst      <= dst;
    memRegsWr   <= wr;
    memLoadType <= lt;
    advance     <= 1'b1;
    flush       <= 1'b0;
endtask

task automatic driveIdle();
    memRegsWr   <= '0;
    memLoadType <= pipePkg::ldNone;
    memWbSel    <= pipePkg::wbAlu;
    advance     <= 1'b1;
    flush       <= 1'b0;
endtask

// counts falling edges until any write port rises
task automatic waitForWrite(input int limit, output int cycles, output bit seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
        @(negedge clk);
        cycles++;
        seen = rfWe || hiWe || loWe;
    end
endtask

task automatic expectNoWrite(input int cycles);
    int waited;
    bit seen;
    waitForWrite(cycles, waited, seen);
    if (seen) begin
        noteFailure($sformatf("unexpected write port activity %0d cycles on", waited));
    end
endtask

task automatic checkWrite(input pipePkg::regsWr_t flags, input pipePkg::regIdx_t dst,
        input pipePkg::word_t data, input pipePkg::word_t hiLo);
    checkFlags("write enables", {loWe, hiWe, rfWe}, flags);
    if (flags[0]) begin
        checkWord("rfAddr", pipePkg::word_t'(rfAddr), pipePkg::word_t'(dst));
        checkWord("rfData", rfData, data);
    end
    if (flags[2:1] != 2'b00) begin
        checkWord("hiLoData", hiLoData, hiLo);
    end
endtask

`endif

// File: verif/tbMemTail.sv
/*
 * Testbench for the MEM2/WB pipeline tail. Resets the DUT, runs the
 * directed tests in turn and prints one line per test and a summary.
 * Build with list.f and top module tbMemTail.
 */

`timescale 1ns/1ps

module tbMemTail;

    logic               clk;
    logic               rstN;
    logic               flush;
    logic               advance;
    pipePkg::word_t     memPc;
    pipePkg::word_t     memAluOut;
    pipePkg::word_t     memOutB;
    pipePkg::wbSel_t    memWbSel;
    pipePkg::regIdx_t   memDst;
    pipePkg::regsWr_t   memRegsWr;
    pipePkg::loadType_t memLoadType;
    pipePkg::word_t     dbusRdata;
    pipePkg::word_t     mem2Result;
    pipePkg::regIdx_t   mem2Dst;
    pipePkg::regsWr_t   mem2RegsWr;
    pipePkg::loadType_t mem2LoadType;
    logic               rfWe;
    pipePkg::regIdx_t   rfAddr;
    pipePkg::word_t     rfData;
    logic               hiWe;
    logic               loWe;
    pipePkg::word_t     hiLoData;

    int checkCount;
    int errorCount;

    memTail i_memTail (
        .clk          (clk),
        .rstN         (rstN),
        .flush        (flush),
        .advance      (advance),
        .memPc        (memPc),
        .memAluOut    (memAluOut),
        .memOutB      (memOutB),
        .memWbSel     (memWbSel),
        .memDst       (memDst),
        .memRegsWr    (memRegsWr),
        .memLoadType  (memLoadType),
        .dbusRdata    (dbusRdata),
        .mem2Result   (mem2Result),
        .mem2Dst      (mem2Dst),
        .mem2RegsWr   (mem2RegsWr),
        .mem2LoadType (mem2LoadType),
        .rfWe         (rfWe),
        .rfAddr       (rfAddr),
        .rfData       (rfData),
        .hiWe         (hiWe),
        .loWe         (loWe),
        .hiLoData     (hiLoData)
    );

    always #5 clk = ~clk; // 10 ns period

    `include "tbChecks.svh"

    task automatic reportTest(input string name, input int errsBefore);
        if (errorCount == errsBefore) begin
            $display("test %-8s ok", name);
        end else begin
            $display("test %-8s FAILED with %0d errors", name, errorCount - errsBefore);
        end
    endtask

    // issue one instruction, check MEM2 and then the write ports
    task automatic runInstr(input pipePkg::wbSel_t sel, input pipePkg::word_t pc,
            input pipePkg::word_t aluOut, input pipePkg::word_t outB,
            input pipePkg::regIdx_t dst, input pipePkg::regsWr_t wr,
            input pipePkg::loadType_t lt, input pipePkg::word_t rdata);
        pipePkg::regsWr_t expFlags;
        pipePkg::word_t   expFwd;
        pipePkg::word_t   expData;
        int               cycles;
        bit               seen;
        expFlags = modelFlags(wr, dst);
        expFwd   = modelBypass(sel, pc, aluOut, outB);
        expData  = (sel == pipePkg::wbLoad) ? modelLoad(lt, aluOut, rdata) : expFwd;
        @(posedge clk);
        driveInstr(sel, pc, aluOut, outB, dst, wr, lt);
        @(posedge clk);
        driveIdle();
        dbusRdata <= rdata; // read word for the MEM2 cycle
        @(negedge clk);
        checkWord("mem2Result", mem2Result, expFwd);
        checkFlags("mem2RegsWr", mem2RegsWr, expFlags);
        checkWord("mem2Dst", pipePkg::word_t'(mem2Dst), pipePkg::word_t'(dst));
        checkWord("mem2LoadType", pipePkg::word_t'(mem2LoadType), pipePkg::word_t'(lt));
        if (expFlags == '0) begin
            expectNoWrite(3);
        end else begin
            waitForWrite(4, cycles, seen);
            if (!seen) begin
                noteFailure("no write port rose within 4 cycles of MEM2");
            end else begin
                if (cycles != 1) begin
                    noteFailure($sformatf("write came %0d cycles after MEM2, not 1", cycles));
                end
                checkWrite(expFlags, dst, expData, expFwd);
            end
        end
    endtask

    task automatic testSelects();
        int errsBefore;
        int i;
        errsBefore = errorCount;
        for (i = 0; i < 3; i++) begin
            runInstr(pipePkg::wbSel_t'(i), randomWord() & 32'hffff_fffc, randomWord(),
                randomWord(), randomDst(), 3'b001, pipePkg::ldNone, randomWord());
        end
        reportTest("selects", errsBefore);
    endtask

    task automatic testLoads();
        int             errsBefore;
        int             lt;
        int             off;
        pipePkg::word_t addr;
        errsBefore = errorCount;
        for (lt = 0; lt < 6; lt++) begin
            for (off = 0; off < 4; off++) begin
                addr = (randomWord() & 32'hffff_fffc) | pipePkg::word_t'(off);
                runInstr(pipePkg::wbLoad, randomWord(), addr, randomWord(), randomDst(),
                    3'b001, pipePkg::loadType_t'(lt), randomWord());
            end
        end
        reportTest("loads", errsBefore);
    endtask

    task automatic testRegZero();
        int errsBefore;
        errsBefore = errorCount;
        runInstr(pipePkg::wbAlu, randomWord(), randomWord(), randomWord(), '0,
            3'b001, pipePkg::ldNone, randomWord());
        // HI write still goes through when dst is r0
        runInstr(pipePkg::wbOperandB, randomWord(), randomWord(), randomWord(), '0,
            3'b011, pipePkg::ldNone, randomWord());
        runInstr(pipePkg::wbOperandB, randomWord(), randomWord(), randomWord(), randomDst(),
            3'b100, pipePkg::ldNone, randomWord());
        reportTest("regzero", errsBefore);
    endtask

    task automatic testFlush();
        int errsBefore;
        errsBefore = errorCount;
        @(posedge clk);
        driveInstr(pipePkg::wbOperandB, randomWord(), randomWord(), randomWord(),
            randomDst(), 3'b111, pipePkg::ldWord);
        flush <= 1'b1; // wins over advance
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkFlags("mem2RegsWr", mem2RegsWr, 3'b000);
        checkWord("mem2Result", mem2Result, '0);
        expectNoWrite(3);
        reportTest("flush", errsBefore);
    endtask

    task automatic testStall();
        int               errsBefore;
        int               i;
        int               cycles;
        bit               seen;
        pipePkg::word_t   pc;
        pipePkg::word_t   expFwd;
        pipePkg::regIdx_t dst;
        errsBefore = errorCount;
        pc     = randomWord() & 32'hffff_fffc;
        dst    = randomDst();
        expFwd = modelBypass(pipePkg::wbLink, pc, '0, '0);
        @(posedge clk);
        driveInstr(pipePkg::wbLink, pc, randomWord(), randomWord(), dst, 3'b001,
            pipePkg::ldNone);
        @(posedge clk);
        // a second instruction waits in MEM while MEM2 is held
        driveInstr(pipePkg::wbAlu, randomWord(), randomWord(), randomWord(), randomDst(),
            3'b001, pipePkg::ldNone);
        advance <= 1'b0;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            checkWord("mem2Result", mem2Result, expFwd);
            checkFlags("mem2RegsWr", mem2RegsWr, 3'b001);
            checkFlags("write enables", {loWe, hiWe, rfWe}, 3'b000);
        end
        @(posedge clk);
        driveIdle();
        waitForWrite(4, cycles, seen);
        if (!seen) begin
            noteFailure("held instruction never wrote after advance returned");
        end else begin
            checkWrite(3'b001, dst, expFwd, expFwd);
        end
        expectNoWrite(3); // exactly one write
        reportTest("stall", errsBefore);
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        flush       = 1'b0;
        advance     = 1'b1; // pending write that reset must drop
        memPc       = '0;
        memAluOut   = '0;
        memOutB     = '0;
        memWbSel    = pipePkg::wbAlu;
        memDst      = 5'd1;
        memRegsWr   = 3'b111;
        memLoadType = pipePkg::ldNone;
        dbusRdata   = '0;
        checkCount  = 0;
        errorCount  = 0;
        void'($urandom(32'ha8cf_e671));

        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        driveIdle();
        @(negedge clk);
        checkFlags("write enables", {loWe, hiWe, rfWe}, 3'b000);
        checkFlags("mem2RegsWr", mem2RegsWr, 3'b000);
        reportTest("reset", 0);

        testSelects();
        testLoads();
        testRegZero();
        testFlush();
        testStall();

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+common
+incdir+verif
common/pipePkg.sv
common/mem2WbIf.sv
mem2/mem2Reg.sv
mem2/bypassSelect.sv
mem2/loadAlign.sv
hdl/wbStage.sv
hdl/memTail.sv
verif/tbMemTail.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tbMemTail
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Checks failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then exit $$status; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
